/* include/pulse_config.svh */
/* build-time constants for the pulse reporter
   BAUD_DIVIDER is sized for short simulations, raise it for a real baud rate
   REPORT_PERIOD must be larger than one full 13 byte line on the wire */
`ifndef PULSE_CONFIG_SVH
`define PULSE_CONFIG_SVH

// counts and durations wrap past 2**width
`define PULSE_COUNTER_WIDTH 16

// decimal digits per field, enough for 65535
`define BCD_DIGITS 5

`define BAUD_DIVIDER 8 // clocks per uart bit

// clocks between checks for a changed count
`define REPORT_PERIOD 4096

`define UART_CREDITS 2 // depth of the tx holding buffer

`endif

/* hdl/pulse_pkg.sv */
/* measurement types of the pulse decoder
   counts and durations are unsigned and wrap silently */
`default_nettype none

`include "pulse_config.svh"

package pulse_pkg;

	// pulse count in scaler mode, or pulse length in clocks in tdc mode
	typedef logic [`PULSE_COUNTER_WIDTH-1:0] measurement_t;

endpackage

`default_nettype wire

/* hdl/report_pkg.sv */
/* types and line layout of the ascii report
   line is count, space, duration, cr, lf with fixed width fields */
`default_nettype none

`include "pulse_config.svh"

package report_pkg;

	typedef logic [`BCD_DIGITS-1:0][3:0] bcd_t; // msd in the top nybble
	typedef logic [7:0] ascii_t;
	typedef logic [$clog2(`UART_CREDITS+1)-1:0] credit_t; // 0 .. UART_CREDITS

	// character positions in one line
	localparam int line_length = 2*`BCD_DIGITS + 3; // 13 for five digits
	localparam int space_position = `BCD_DIGITS;
	localparam int cr_position = line_length - 2;
	localparam int lf_position = line_length - 1; // last byte of the line

	localparam ascii_t ascii_zero = 8'h30; // digit offset
	localparam ascii_t ascii_space = 8'h20;
	localparam ascii_t ascii_cr = 8'h0d;
	localparam ascii_t ascii_lf = 8'h0a;

endpackage

`default_nettype wire

/* hdl/pulse_decoder.sv */
/* trigger is asynchronous, two flops of synchronizer before any use
   a pulse is counted 3 to 4 clocks after it ends, length in sampled-high clocks
   pulses shorter than one clock period may be missed */
`timescale 1ns/1ps
`default_nettype none

module pulse_decoder (
	input wire logic clock,
	input wire logic reset,
	input wire logic trigger,
	output pulse_pkg::measurement_t pulse_count,
	output pulse_pkg::measurement_t last_duration
);
	import pulse_pkg::*;

	// [0] and [1] synchronize, [2] holds the previous level for edge detect
	logic [2:0] history;
	logic falling_edge;
	logic fall_seen; // falling edge, one clock later
	measurement_t live_duration; // grows while the pulse is high

	assign falling_edge = history[2] && !history[1]; // 1 then 0

	always_ff @(posedge clock) begin
		if (reset) begin
			history <= '0;
			fall_seen <= 1'b0;
			live_duration <= '0;
			pulse_count <= '0;
			last_duration <= '0;
		end else begin
			history <= {history[1:0], trigger};
			fall_seen <= falling_edge;
			if (fall_seen) begin
				last_duration <= live_duration; // tdc mode
				pulse_count <= pulse_count + 1'b1; // scaler mode, wraps
				// a new pulse may already be high after a one clock gap
				live_duration <= measurement_t'(history[1]);
			end else if (history[1]) begin
				live_duration <= live_duration + 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/bcd_converter.sv */
/* double dabble, one input bit per clock
   done follows start by PULSE_COUNTER_WIDTH+1 clocks, start while busy is dropped
   bcd_out holds its value until the next conversion finishes */
`timescale 1ns/1ps
`default_nettype none

`include "pulse_config.svh"

module bcd_converter (
	input wire logic clock,
	input wire logic reset,
	input wire logic convert_start,
	input wire pulse_pkg::measurement_t binary_in,
	output logic convert_done,
	output report_pkg::bcd_t bcd_out
);
	import pulse_pkg::*;
	import report_pkg::*;

	localparam int count_width = $clog2(`PULSE_COUNTER_WIDTH + 1);

	logic [count_width-1:0] bits_left; // input bits still to shift in
	logic running;
	measurement_t binary_shift; // msb goes into the bcd side next
	bcd_t bcd_work;
	bcd_t bcd_adjusted; // after add three
	bcd_t bcd_shifted;

	assign running = bits_left != '0;

	// any digit of 5 or more would overflow when doubled
	always_comb begin
		for (int digit = 0; digit < `BCD_DIGITS; digit++) begin
			if (bcd_work[digit] > 4'd4) begin
				bcd_adjusted[digit] = bcd_work[digit] + 4'd3;
			end else begin
				bcd_adjusted[digit] = bcd_work[digit];
			end
		end
	end

	// top bit drops off, it is always zero for 16 bit input
	assign bcd_shifted = bcd_t'({bcd_adjusted, binary_shift[`PULSE_COUNTER_WIDTH-1]});

	always_ff @(posedge clock) begin
		if (reset) begin
			bits_left <= '0;
			convert_done <= 1'b0;
		end else begin
			convert_done <= 1'b0;
			if (!running && convert_start) begin
				bits_left <= count_width'(`PULSE_COUNTER_WIDTH);
			end else if (running) begin
				bits_left <= bits_left - 1'b1;
				convert_done <= bits_left == count_width'(1); // last bit this clock
			end
		end
	end

	always_ff @(posedge clock) begin
		if (!running && convert_start) begin
			binary_shift <= binary_in;
			bcd_work <= '0;
		end else if (running) begin
			binary_shift <= binary_shift << 1;
			bcd_work <= bcd_shifted;
		end
		if (running && bits_left == count_width'(1)) begin
			bcd_out <= bcd_shifted;
		end
	end

endmodule

`default_nettype wire

/* hdl/report_formatter.sv */
/* reports only when the pulse count changed since the last line
   snapshot is taken at timer expiry, expiries during a line are dropped
   bytes go out only against credits from the uart buffer */
`timescale 1ns/1ps
`default_nettype none

`include "pulse_config.svh"

module report_formatter (
	input wire logic clock,
	input wire logic reset,
	input wire pulse_pkg::measurement_t pulse_count,
	input wire pulse_pkg::measurement_t last_duration,
	input wire logic count_done,
	input wire report_pkg::bcd_t count_bcd,
	input wire report_pkg::bcd_t duration_bcd,
	input wire logic credit_return,
	output logic convert_start,
	output pulse_pkg::measurement_t count_binary,
	output pulse_pkg::measurement_t duration_binary,
	output logic byte_valid,
	output report_pkg::ascii_t byte_data,
	output logic busy
);
	import pulse_pkg::*;
	import report_pkg::*;

	typedef enum logic [1:0] {
		state_idle,
		state_converting,
		state_sending,
		state_finishing // waits for the buffer to drain
	} state_t;

	localparam int timer_width = $clog2(`REPORT_PERIOD);
	localparam int index_width = $clog2(line_length);

	state_t state;
	logic [timer_width-1:0] period_timer;
	logic period_expired;
	logic start_report;
	measurement_t last_reported;
	credit_t credits; // free entries in the uart buffer
	logic [index_width-1:0] char_index;
	int digit_index;

	assign period_expired = period_timer == timer_width'(`REPORT_PERIOD - 1);
	assign start_report = state == state_idle && period_expired && pulse_count != last_reported;
	assign busy = state != state_idle;
	assign byte_valid = state == state_sending && credits != '0; // stall at zero

	always_ff @(posedge clock) begin
		if (reset || period_expired) begin
			period_timer <= '0;
		end else begin
			period_timer <= period_timer + 1'b1;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			credits <= credit_t'(`UART_CREDITS); // buffer starts empty
		end else if (credit_return && !byte_valid) begin
			credits <= credits + 1'b1;
		end else if (byte_valid && !credit_return) begin
			credits <= credits - 1'b1;
		end
	end

	// both fields frozen for the whole line
	always_ff @(posedge clock) begin
		if (start_report) begin
			count_binary <= pulse_count;
			duration_binary <= last_duration;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			state <= state_idle;
			convert_start <= 1'b0;
			last_reported <= '0;
			char_index <= '0;
		end else begin
			convert_start <= 1'b0;
			case (state)
				state_idle: begin
					if (start_report) begin
						last_reported <= pulse_count;
						convert_start <= 1'b1; // both converters at once
						state <= state_converting;
					end
				end
				state_converting: begin
					if (count_done) begin // duration finishes on the same clock
						char_index <= '0;
						state <= state_sending;
					end
				end
				state_sending: begin
					if (byte_valid) begin
						if (char_index == index_width'(lf_position)) begin
							state <= state_finishing;
						end else begin
							char_index <= char_index + 1'b1;
						end
					end
				end
				state_finishing: begin
					if (credits == credit_t'(`UART_CREDITS)) begin
						state <= state_idle;
					end
				end
				default: state <= state_idle;
			endcase
		end
	end

	// character select, digits come out msd first
	always_comb begin
		digit_index = 0;
		byte_data = ascii_lf;
		if (char_index < space_position) begin
			digit_index = space_position - 1 - int'(char_index);
			byte_data = ascii_zero + ascii_t'(count_bcd[digit_index]);
		end else if (char_index == space_position) begin
			byte_data = ascii_space;
		end else if (char_index < cr_position) begin
			digit_index = cr_position - 1 - int'(char_index);
			byte_data = ascii_zero + ascii_t'(duration_bcd[digit_index]);
		end else if (char_index == cr_position) begin
			byte_data = ascii_cr;
		end
	end

endmodule

`default_nettype wire

/* hdl/uart_transmitter.sv */
/* 8N1 transmitter, BAUD_DIVIDER clocks per bit, no parity
   writes are not checked against a full buffer, the sender must hold credits
   one credit comes back as each byte enters the shift register */
`timescale 1ns/1ps
`default_nettype none

`include "pulse_config.svh"

module uart_transmitter (
	input wire logic clock,
	input wire logic reset,
	input wire logic byte_valid,
	input wire report_pkg::ascii_t byte_data,
	output logic credit_return,
	output logic tx
);
	import report_pkg::*;

	localparam int depth = `UART_CREDITS;
	localparam int pointer_width = depth > 1 ? $clog2(depth) : 1;
	localparam int baud_width = `BAUD_DIVIDER > 1 ? $clog2(`BAUD_DIVIDER) : 1;

	ascii_t fifo_data [depth];
	logic [pointer_width-1:0] write_pointer;
	logic [pointer_width-1:0] read_pointer;
	credit_t fifo_count;
	logic [9:0] frame; // stop, data, start, shifted out from bit 0
	logic [3:0] bits_left; // 0 when the line is idle
	logic [baud_width-1:0] baud_count;
	logic load_frame;

	assign load_frame = bits_left == 4'd0 && fifo_count != '0;
	assign credit_return = load_frame; // entry freed this clock
	assign tx = frame[0];

	always_ff @(posedge clock) begin
		if (byte_valid) begin
			fifo_data[write_pointer] <= byte_data;
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			write_pointer <= '0;
			read_pointer <= '0;
			fifo_count <= '0;
		end else begin
			if (byte_valid) begin
				write_pointer <= write_pointer == pointer_width'(depth - 1) ?
					'0 : write_pointer + 1'b1;
			end
			if (load_frame) begin
				read_pointer <= read_pointer == pointer_width'(depth - 1) ?
					'0 : read_pointer + 1'b1;
			end
			case ({byte_valid, load_frame})
				2'b10: fifo_count <= fifo_count + 1'b1;
				2'b01: fifo_count <= fifo_count - 1'b1;
				default: fifo_count <= fifo_count; // none, or push and pop
			endcase
		end
	end

	always_ff @(posedge clock) begin
		if (reset) begin
			frame <= '1; // line idles high
			bits_left <= 4'd0;
			baud_count <= '0;
		end else if (load_frame) begin
			frame <= {1'b1, fifo_data[read_pointer], 1'b0}; // lsb first after start
			bits_left <= 4'd10;
			baud_count <= baud_width'(`BAUD_DIVIDER - 1);
		end else if (bits_left != 4'd0) begin
			if (baud_count == '0) begin
				frame <= {1'b1, frame[9:1]}; // ones refill, idle after stop
				bits_left <= bits_left - 1'b1;
				baud_count <= baud_width'(`BAUD_DIVIDER - 1);
			end else begin
				baud_count <= baud_count - 1'b1;
			end
		end
	end

endmodule

`default_nettype wire

/* hdl/pulse_reporter_top.sv */
/* pulse counter and length meter with a periodic uart report
   all logic on one clock, trigger may be fully asynchronous */
`timescale 1ns/1ps
`default_nettype none

module pulse_reporter_top (
	input wire logic clock,
	input wire logic reset,
	input wire logic trigger,
	output logic tx,
	output logic busy
);
	import pulse_pkg::*;
	import report_pkg::*;

	measurement_t pulse_count;
	measurement_t last_duration;
	measurement_t count_binary; // snapshots held by the formatter
	measurement_t duration_binary;
	bcd_t count_bcd;
	bcd_t duration_bcd;
	logic convert_start;
	logic count_done;
	logic byte_valid;
	logic credit_return;
	ascii_t byte_data;

	pulse_decoder decoder (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.pulse_count(pulse_count),
		.last_duration(last_duration)
	);

	bcd_converter count_converter (
		.clock(clock),
		.reset(reset),
		.convert_start(convert_start),
		.binary_in(count_binary),
		.convert_done(count_done),
		.bcd_out(count_bcd)
	);

	// same latency as the count converter, its done is redundant
	bcd_converter duration_converter (
		.clock(clock),
		.reset(reset),
		.convert_start(convert_start),
		.binary_in(duration_binary),
		.convert_done(),
		.bcd_out(duration_bcd)
	);

	report_formatter formatter (
		.clock(clock),
		.reset(reset),
		.pulse_count(pulse_count),
		.last_duration(last_duration),
		.count_done(count_done),
		.count_bcd(count_bcd),
		.duration_bcd(duration_bcd),
		.credit_return(credit_return),
		.convert_start(convert_start),
		.count_binary(count_binary),
		.duration_binary(duration_binary),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.busy(busy)
	);

	uart_transmitter transmitter (
		.clock(clock),
		.reset(reset),
		.byte_valid(byte_valid),
		.byte_data(byte_data),
		.credit_return(credit_return),
		.tx(tx)
	);

endmodule

`default_nettype wire

/* verification/pulse_reporter_tb.sv */
/* drives trigger pulses on the falling clock edge and decodes the uart line
   assumes BAUD_DIVIDER clocks per bit and a report line at most once a period */
`timescale 1ns/1ps
`default_nettype none

`include "pulse_config.svh"

module pulse_reporter_tb;
	localparam int line_length = 13; // five digits, space, five digits, cr, lf
	localparam int cycle_limit = 12 * `REPORT_PERIOD + 1000;

	logic clock;
	logic reset;
	logic trigger;
	wire tx;
	wire busy;

	int cycle_count = 0;
	int errors = 0;
	int frame_errors = 0; // uart monitor only
	int frames_received = 0;
	int lines_received = 0;
	int char_count = 0;
	int tests_run = 0;
	int tests_failed = 0;
	logic [31:0] lcg_state = 32'h596a;
	logic [7:0] line_buffer [line_length];
	logic [7:0] last_line [line_length]; // latest complete line

	pulse_reporter_top DUT (
		.clock(clock),
		.reset(reset),
		.trigger(trigger),
		.tx(tx),
		.busy(busy)
	);

	initial begin
		clock = 1'b0;
		forever #5 clock = ~clock;
	end

	always @(posedge clock) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count == cycle_limit) begin
			$display("timeout after %0d cycles, a line or busy edge never came", cycle_limit);
			$display("*** FAILED ***");
			$finish;
		end
	end

	function automatic logic [31:0] next_random();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16; // low bits of an lcg repeat too soon
	endfunction

	// ascii of one character of the expected line
	function automatic logic [7:0] expected_char(input int count, input int duration,
			input int position);
		int value;
		int digit;
		int power;
		if (position == 5) return 8'h20;
		if (position == line_length - 2) return 8'h0d;
		if (position == line_length - 1) return 8'h0a;
		value = position < 5 ? count : duration;
		digit = position < 5 ? position : position - 6; // 0 is most significant
		power = 1;
		repeat (4 - digit) power = power * 10;
		return 8'h30 + 8'((value / power) % 10);
	endfunction

	task automatic wait_cycles(input int cycles);
		repeat (cycles) @(negedge clock);
	endtask

	task automatic drive_pulse(input int length);
		trigger = 1'b1;
		wait_cycles(length); // high at exactly length rising edges
		trigger = 1'b0;
	endtask

	task automatic wait_for_line(input int target);
		while (lines_received < target) begin
			@(negedge clock);
		end
	endtask

	task automatic check_line(input int count, input int duration);
		logic [7:0] expected;
		for (int position = 0; position < line_length; position++) begin
			expected = expected_char(count, duration, position);
			assert (last_line[position] === expected) else begin
				$display("FAIL %0t line_char[%0d] got 0x%02h expected 0x%02h",
					$time, position, last_line[position], expected);
				errors++;
			end
		end
	endtask

	task automatic finish_test(input int number, input string name, input logic passed);
		tests_run++;
		if (!passed) tests_failed++;
		$display("test %0d %s: %s", number, name, passed ? "ok" : "failed");
	endtask

	// 8 negedge samples per bit, all must agree, value taken mid bit
	task automatic receive_frame(output logic [7:0] data);
		logic samples [`BAUD_DIVIDER];
		logic level;
		for (int bit_number = 0; bit_number < 10; bit_number++) begin
			for (int sample = 0; sample < `BAUD_DIVIDER; sample++) begin
				if (bit_number > 0 || sample > 0) @(negedge clock);
				samples[sample] = tx;
			end
			level = samples[`BAUD_DIVIDER / 2];
			for (int sample = 0; sample < `BAUD_DIVIDER; sample++) begin
				assert (samples[sample] === level) else begin
					$display("FAIL %0t tx got %b expected %b in bit %0d",
						$time, samples[sample], level, bit_number);
					frame_errors++;
				end
			end
			if (bit_number == 0) begin
				assert (level === 1'b0) else begin
					$display("start bit not low at %0t", $time);
					frame_errors++;
				end
			end else if (bit_number == 9) begin
				assert (level === 1'b1) else begin
					$display("stop bit low at %0t, framing error", $time);
					frame_errors++;
				end
			end else begin
				data[bit_number - 1] = level; // lsb first
			end
		end
	endtask

	task automatic store_byte(input logic [7:0] data);
		if (char_count < line_length) line_buffer[char_count] = data;
		char_count++;
		if (data == 8'h0a) begin
			assert (char_count == line_length) else begin
				$display("line of %0d characters at %0t, bytes lost or extra",
					char_count, $time);
				frame_errors++;
			end
			last_line = line_buffer;
			lines_received++;
			char_count = 0;
		end
	endtask

	initial begin : uart_monitor
		logic previous_level;
		logic [7:0] rx_byte;
		previous_level = 1'b1;
		forever begin
			@(negedge clock);
			if (!reset && previous_level && !tx) begin // start bit edge
				receive_frame(rx_byte);
				frames_received++;
				store_byte(rx_byte);
				previous_level = 1'b1;
			end else begin
				previous_level = tx;
			end
		end
	end

	initial begin
		int errors_before;
		int expected_count;
		int length;
		int lines_before;
		logic quiet;
		reset = 1'b1;
		trigger = 1'b0;
		wait_cycles(2);
		reset = 1'b0;

		// no pulses, so no report in two periods
		errors_before = errors;
		quiet = 1'b1;
		repeat (2 * `REPORT_PERIOD) begin
			@(negedge clock);
			assert (tx === 1'b1 && busy === 1'b0) else begin
				if (quiet) begin
					$display("line active with no pulses at %0t, tx %b busy %b", $time, tx, busy);
					errors++;
				end
				quiet = 1'b0;
			end
		end
		finish_test(1, "idle after reset", errors == errors_before);

		errors_before = errors;
		drive_pulse(37);
		expected_count = 1;
		wait_for_line(1);
		check_line(expected_count, 37);
		finish_test(2, "single 37 cycle pulse", errors == errors_before);

		// burst must fit before the next expiry, line just ended
		errors_before = errors;
		for (int pulse = 0; pulse < 8; pulse++) begin
			wait_cycles(2 + next_random() % 100);
			length = 1 + next_random() % 200;
			drive_pulse(length);
		end
		expected_count += 8;
		wait_for_line(2);
		check_line(expected_count, length);
		finish_test(3, "eight random pulses", errors == errors_before);

		errors_before = errors;
		lines_before = lines_received;
		quiet = 1'b1;
		repeat (`REPORT_PERIOD + 100) begin
			@(negedge clock);
			assert (busy === 1'b0) else begin
				if (quiet) begin
					$display("report started at %0t with an unchanged count", $time);
					errors++;
				end
				quiet = 1'b0;
			end
		end
		assert (lines_received == lines_before) else begin
			$display("a line was sent although no pulse arrived");
			errors++;
		end
		finish_test(4, "no line without new pulses", errors == errors_before);

		// second pulse ends while the first is being reported
		errors_before = errors;
		wait_cycles(10);
		drive_pulse(40);
		expected_count++;
		while (!busy) begin
			@(negedge clock);
		end
		drive_pulse(50);
		wait_cycles(5);
		assert (busy === 1'b1) else begin
			$display("report ended before the late pulse was counted");
			errors++;
		end
		wait_for_line(3);
		check_line(expected_count, 40);
		expected_count++;
		wait_for_line(4);
		check_line(expected_count, 50);
		finish_test(6, "pulse during a report", errors == errors_before);

		assert (frames_received == 4 * line_length) else begin
			$display("%0d frames decoded instead of %0d", frames_received, 4 * line_length);
			frame_errors++;
		end
		finish_test(5, "uart framing and line length", frame_errors == 0);

		$display("tests run %0d, failed %0d, value errors %0d, framing errors %0d",
			tests_run, tests_failed, errors, frame_errors);
		if (tests_failed == 0) begin
			$display("*** PASSED ***");
		end else begin
			$display("*** FAILED ***");
		end
		$finish;
	end

endmodule

`default_nettype wire

/* files.f */
+incdir+include
hdl/pulse_pkg.sv
hdl/report_pkg.sv
hdl/pulse_decoder.sv
hdl/bcd_converter.sv
hdl/report_formatter.sv
hdl/uart_transmitter.sv
hdl/pulse_reporter_top.sv
verification/pulse_reporter_tb.sv

/* run.sh */
#!/bin/sh
# build the pulse reporter testbench with verilator and run it
# the exit status is 0 only when the testbench prints its pass line
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal -f files.f \
	--top-module pulse_reporter_tb -Mdir obj_dir &&
./obj_dir/Vpulse_reporter_tb | tee /dev/stderr | grep -F '*** PASSED ***' > /dev/null &&
echo "simulation passed" ||
{ echo "simulation failed"; exit 1; }
